// ==== design/dcache_pkg.sv ====
// Data cache constants, width types and the controller state encoding
`default_nettype none

package dcache_pkg;

  // Cache geometry
  localparam int NUM_LINES      = 4;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_IDX_W     = 2;

  // Address and data widths
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int LINE_W     = WORD_W * WORDS_PER_LINE;
  localparam int OFFSET_W   = 4;
  localparam int BYTE_OFF_W = 2;
  localparam int TAG_W      = ADDR_W - OFFSET_W;
  localparam int AGE_W      = 2;

  typedef logic [ADDR_W-1:0]              addr_t;
  typedef logic [WORD_W-1:0]              word_t;
  // Word 0 sits in the low bits
  typedef logic [LINE_W-1:0]              line_t;
  typedef logic [TAG_W-1:0]               tag_t;
  typedef logic [LINE_IDX_W-1:0]          line_idx_t;
  typedef logic [AGE_W-1:0]               age_t;
  typedef logic [OFFSET_W-BYTE_OFF_W-1:0] word_sel_t;
  typedef logic [BYTE_OFF_W-1:0]          byte_sel_t;

  // Age of the most recently used line, 0 marks the victim
  localparam age_t AGE_MRU = age_t'(NUM_LINES - 1);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REQUEST,
    WRITEBACK,
    REFILL,
    RELEASE,
    COMPLETE
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/cache_line.sv ====
// Single cache line: tag, valid, dirty, LRU age, four data words
// and the tag compare for the current request
`timescale 1ns/1ns
`default_nettype none

module cache_line
  import dcache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  line_idx_t line_id,
  input  tag_t      req_tag,
  input  word_sel_t req_word,
  input  byte_sel_t req_byte,
  input  word_t     wr_data,
  input  line_idx_t sel_line,
  input  logic      store_en,
  input  logic      store_byte,
  input  logic      fill_en,
  input  line_t     fill_data,
  input  logic      touch_en,
  input  age_t      touch_age,
  output logic      hit,
  output logic      valid,
  output logic      dirty,
  output age_t      age,
  output tag_t      tag,
  output line_t     data
);

  logic selected;

  assign selected = (sel_line == line_id);
  assign hit      = valid && (tag == req_tag);

  // Line state and LRU age
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid <= 1'b0;
      dirty <= 1'b0;
      age   <= age_t'(line_id);
    end
    else
    begin
      if (fill_en && selected)
      begin
        valid <= 1'b1;
        dirty <= 1'b0;
      end
      else if (store_en && selected)
      begin
        dirty <= 1'b1;
      end

      // Touched line becomes MRU, younger lines age by one
      if (touch_en)
      begin
        if (selected)
          age <= AGE_MRU;
        else if (age > touch_age)
          age <= age - 1'b1;
      end
    end
  end

  // Tag and data words
  always_ff @(posedge clk)
  begin
    if (fill_en && selected)
    begin
      data <= fill_data;
      tag  <= req_tag;
    end
    else if (store_en && selected)
    begin
      if (store_byte)
        data[{req_word, req_byte, 3'b000} +: 8] <= wr_data[7:0];
      else
        data[{req_word, 5'b00000} +: WORD_W] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/line_select.sv ====
// Hit and victim encoding, load word extraction and victim muxing
`timescale 1ns/1ns
`default_nettype none

module line_select
  import dcache_pkg::*;
(
  input  logic [NUM_LINES-1:0]   hit_vec,
  input  age_t [NUM_LINES-1:0]   age_vec,
  input  logic [NUM_LINES-1:0]   dirty_vec,
  input  tag_t [NUM_LINES-1:0]   tag_vec,
  input  line_t [NUM_LINES-1:0]  data_vec,
  input  word_sel_t              req_word,
  input  byte_sel_t              req_byte,
  input  logic                   byte_op,
  output logic                   any_hit,
  output line_idx_t              hit_idx,
  output line_idx_t              victim_idx,
  output logic                   victim_dirty,
  output tag_t                   victim_tag,
  output line_t                  victim_line,
  output age_t                   hit_age,
  output word_t                  load_word
);

  line_t       hit_line;
  word_t       hit_word;
  logic [7:0]  hit_byte;

  // Lowest hitting index wins, victim is the line with age 0
  always_comb
  begin
    hit_idx    = '0;
    victim_idx = '0;
    for (int i = NUM_LINES - 1; i >= 0; i--)
    begin
      if (hit_vec[i])
        hit_idx = line_idx_t'(i);
      if (age_vec[i] == '0)
        victim_idx = line_idx_t'(i);
    end
  end

  assign any_hit = |hit_vec;
  assign hit_age = age_vec[hit_idx];

  // Load path, bytes come back zero-extended
  assign hit_line  = data_vec[hit_idx];
  assign hit_word  = hit_line[{req_word, 5'b00000} +: WORD_W];
  assign hit_byte  = hit_word[{req_byte, 3'b000} +: 8];
  assign load_word = byte_op ? word_t'(hit_byte) : hit_word;

  // Write-back data for the victim
  assign victim_dirty = dirty_vec[victim_idx];
  assign victim_tag   = tag_vec[victim_idx];
  assign victim_line  = data_vec[victim_idx];

endmodule

`default_nettype wire

// ==== design/cache_controller.sv ====
// Cache controller: request capture, hit/miss FSM, memory port sequencing
// and the store, fill and touch commands broadcast to the lines
`timescale 1ns/1ns
`default_nettype none

module cache_controller
  import dcache_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  access,
  input  logic                  op,
  input  logic                  byte_op,
  input  addr_t                 address,
  input  word_t                 data_in,
  input  logic                  any_hit,
  input  line_idx_t             hit_idx,
  input  line_idx_t             victim_idx,
  input  logic                  victim_dirty,
  input  tag_t                  victim_tag,
  input  line_t                 victim_line,
  input  age_t                  hit_age,
  input  age_t [NUM_LINES-1:0]  line_ages,
  input  word_t                 load_word,
  input  logic                  allow_op,
  input  logic                  mem_data_ready,
  input  line_t                 mem_data_out,
  output tag_t                  req_tag,
  output word_sel_t             req_word,
  output byte_sel_t             req_byte,
  output word_t                 wr_data,
  output logic                  store_en,
  output logic                  store_byte,
  output logic                  fill_en,
  output line_t                 fill_data,
  output logic                  touch_en,
  output age_t                  touch_age,
  output line_idx_t             sel_line,
  output logic                  req_byte_op,
  output word_t                 data_out,
  output logic                  data_ready,
  output logic                  mem_op_init,
  output logic                  mem_op_done,
  output logic                  mem_op,
  output logic                  start_access,
  output addr_t                 mem_address,
  output line_t                 mem_data_in
);

  ctrl_state_t state;
  addr_t       addr_q;
  word_t       data_q;
  logic        op_q;
  logic        byte_op_q;
  logic        wb_q;
  line_idx_t   target_q;
  logic        hit_phase;
  addr_t       refill_addr;

  // Lookup runs for a new request and again right after the refill
  assign hit_phase   = (state == LOOKUP) || (state == RELEASE);
  assign refill_addr = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // Request fields broadcast to every line
  assign req_tag     = addr_q[ADDR_W-1:OFFSET_W];
  assign req_word    = addr_q[OFFSET_W-1:BYTE_OFF_W];
  assign req_byte    = addr_q[BYTE_OFF_W-1:0];
  assign wr_data     = data_q;
  assign store_byte  = byte_op_q;
  assign req_byte_op = byte_op_q;
  assign fill_data   = mem_data_out;

  assign fill_en   = (state == REFILL) && start_access && mem_data_ready;
  assign store_en  = hit_phase && any_hit && !op_q;
  assign touch_en  = (hit_phase && any_hit) || fill_en;
  assign sel_line  = (state == REFILL) ? target_q : hit_idx;
  assign touch_age = (state == REFILL) ? line_ages[target_q] : hit_age;

  assign data_ready  = (state == COMPLETE);
  assign mem_op_done = (state == RELEASE);
  assign mem_op      = (state == WRITEBACK);
  assign mem_op_init = (state == REQUEST) || (state == WRITEBACK) || (state == REFILL);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state        <= IDLE;
      start_access <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
          if (access)
            state <= LOOKUP;
        LOOKUP:
          state <= any_hit ? COMPLETE : REQUEST;
        REQUEST:
          if (allow_op)
          begin
            start_access <= 1'b1;
            state        <= wb_q ? WRITEBACK : REFILL;
          end
        WRITEBACK:
          if (mem_data_ready)
          begin
            start_access <= 1'b0;
            state        <= REFILL;
          end
        REFILL:
          // One idle cycle between write-back and refill transfers
          if (!start_access)
            start_access <= 1'b1;
          else if (mem_data_ready)
          begin
            start_access <= 1'b0;
            state        <= RELEASE;
          end
        RELEASE:
          state <= COMPLETE;
        COMPLETE:
          state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // Captured request, victim and memory port data
  always_ff @(posedge clk)
  begin
    if ((state == IDLE) && access)
    begin
      addr_q    <= address;
      data_q    <= data_in;
      op_q      <= op;
      byte_op_q <= byte_op;
    end
    if (hit_phase && any_hit)
      data_out <= load_word;
    if ((state == LOOKUP) && !any_hit)
    begin
      target_q    <= victim_idx;
      wb_q        <= victim_dirty;
      mem_data_in <= victim_line;
      mem_address <= victim_dirty ? {victim_tag, {OFFSET_W{1'b0}}} : refill_addr;
    end
    if ((state == WRITEBACK) && mem_data_ready)
      mem_address <= refill_addr;
  end

endmodule

`default_nettype wire

// ==== design/dcache.sv ====
// Data cache top: controller, the array of four lines and the line selector
`timescale 1ns/1ns
`default_nettype none

module dcache
  import dcache_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  access,
  input  logic  op,
  input  logic  byte_op,
  input  addr_t address,
  input  word_t data_in,
  output word_t data_out,
  output logic  data_ready,
  output logic  mem_op_init,
  input  logic  allow_op,
  output addr_t mem_address,
  output logic  mem_op,
  output line_t mem_data_in,
  output logic  start_access,
  input  logic  mem_data_ready,
  input  line_t mem_data_out,
  output logic  mem_op_done
);

  // Broadcast from the controller
  tag_t      req_tag;
  word_sel_t req_word;
  byte_sel_t req_byte;
  word_t     wr_data;
  logic      store_en;
  logic      store_byte;
  logic      fill_en;
  line_t     fill_data;
  logic      touch_en;
  age_t      touch_age;
  line_idx_t sel_line;
  logic      req_byte_op;

  // Per-line outputs
  logic [NUM_LINES-1:0]  hit_vec;
  logic [NUM_LINES-1:0]  valid_vec;
  logic [NUM_LINES-1:0]  dirty_vec;
  age_t [NUM_LINES-1:0]  age_vec;
  tag_t [NUM_LINES-1:0]  tag_vec;
  line_t [NUM_LINES-1:0] data_vec;

  // Selector results
  logic      any_hit;
  line_idx_t hit_idx;
  line_idx_t victim_idx;
  logic      victim_dirty;
  tag_t      victim_tag;
  line_t     victim_line;
  age_t      hit_age;
  word_t     load_word;

  cache_controller i_controller (
    .clk, .reset, .access, .op, .byte_op, .address, .data_in,
    .any_hit, .hit_idx, .victim_idx, .victim_dirty, .victim_tag, .victim_line,
    .hit_age, .line_ages(age_vec), .load_word,
    .allow_op, .mem_data_ready, .mem_data_out,
    .req_tag, .req_word, .req_byte, .wr_data, .store_en, .store_byte,
    .fill_en, .fill_data, .touch_en, .touch_age, .sel_line, .req_byte_op,
    .data_out, .data_ready, .mem_op_init, .mem_op_done, .mem_op,
    .start_access, .mem_address, .mem_data_in
  );

  for (genvar g = 0; g < NUM_LINES; g++)
  begin : g_line
    cache_line i_line (
      .clk, .reset, .line_id(line_idx_t'(g)),
      .req_tag, .req_word, .req_byte, .wr_data, .sel_line,
      .store_en, .store_byte, .fill_en, .fill_data, .touch_en, .touch_age,
      .hit(hit_vec[g]), .valid(valid_vec[g]), .dirty(dirty_vec[g]),
      .age(age_vec[g]), .tag(tag_vec[g]), .data(data_vec[g])
    );
  end

  // Only valid lines count as dirty victims
  line_select i_select (
    .hit_vec, .age_vec, .dirty_vec(dirty_vec & valid_vec), .tag_vec, .data_vec,
    .req_word, .req_byte, .byte_op(req_byte_op),
    .any_hit, .hit_idx, .victim_idx, .victim_dirty, .victim_tag, .victim_line,
    .hit_age, .load_word
  );

endmodule

`default_nettype wire

// ==== tb/tb_line_memory.sv ====
// Arbiter and line memory model for the cache memory port
`timescale 1ns/1ns
`default_nettype none

module tb_line_memory
  import dcache_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  mem_op_init,
  input  logic  mem_op,
  input  logic  start_access,
  input  logic  mem_op_done,
  input  addr_t mem_address,
  input  line_t mem_data_in,
  output logic  allow_op,
  output logic  mem_data_ready,
  output line_t mem_data_out
);

  line_t lines [addr_t];
  int    grant_wait;
  int    access_wait;

  // Untouched words start from a pattern of their own address
  function automatic word_t initial_word(addr_t a);
    return a ^ {a[7:0], a[31:8]} ^ 32'hc3a5_1e0f;
  endfunction

  function automatic line_t read_line(addr_t base);
    line_t l;
    if (lines.exists(base))
      return lines[base];
    for (int w = 0; w < WORDS_PER_LINE; w++)
      l[w*WORD_W +: WORD_W] = initial_word(base + addr_t'(4 * w));
    return l;
  endfunction

  // Outputs change on the falling edge, grant after 2 cycles, transfer after 3
  always @(negedge clk or posedge reset)
  begin
    if (reset)
    begin
      allow_op       <= 1'b0;
      mem_data_ready <= 1'b0;
      mem_data_out   <= '0;
      grant_wait     <= 0;
      access_wait    <= 0;
    end
    else
    begin
      if (mem_op_done)
      begin
        allow_op   <= 1'b0;
        grant_wait <= 0;
      end
      else if (mem_op_init && !allow_op)
      begin
        if (grant_wait == 1)
          allow_op <= 1'b1;
        else
          grant_wait <= grant_wait + 1;
      end

      if (mem_data_ready)
      begin
        mem_data_ready <= 1'b0;
        access_wait    <= 0;
      end
      else if (start_access)
      begin
        if (access_wait == 2)
        begin
          mem_data_ready <= 1'b1;
          if (mem_op)
            lines[mem_address] = mem_data_in;
          else
            mem_data_out <= read_line(mem_address);
        end
        else
          access_wait <= access_wait + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_dcache.sv ====
// Testbench top with clock, reset, random accesses, reference model,
// transaction monitor, typed compares and a watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
  import dcache_pkg::*;

  localparam int     NUM_ACCESSES = 200;
  localparam longint WATCHDOG_NS  = (NUM_ACCESSES + 4) * 60 * 20;

  logic  clk;
  logic  reset;
  logic  access;
  logic  op;
  logic  byte_op;
  addr_t address;
  word_t data_in;
  word_t data_out;
  logic  data_ready;
  logic  mem_op_init;
  logic  allow_op;
  addr_t mem_address;
  logic  mem_op;
  line_t mem_data_in;
  logic  start_access;
  logic  mem_data_ready;
  line_t mem_data_out;
  logic  mem_op_done;

  // Reference model state
  word_t     shadow [addr_t];
  tag_t      ref_tag   [NUM_LINES];
  logic      ref_valid [NUM_LINES];
  logic      ref_dirty [NUM_LINES];
  age_t      ref_age   [NUM_LINES];
  logic [15:0] lfsr_state = 16'd59576;

  // Expectations for the access in flight
  logic  exp_read;
  word_t exp_load;
  logic  exp_miss;
  logic  exp_wb;
  addr_t exp_wb_addr;
  line_t exp_wb_line;
  addr_t exp_refill_addr;
  logic  pending;
  int    cyc;
  int    n_xfer;
  logic  xfer_end;
  int    done_cnt;
  int    done_cyc;

  addr_t line_bases [6] = '{32'h0000_1000, 32'h0000_2040, 32'h8000_0010,
                            32'h1234_5670, 32'h0abc_def0, 32'h0000_0030};

  dcache i_dut (
    .clk, .reset, .access, .op, .byte_op, .address, .data_in, .data_out,
    .data_ready, .mem_op_init, .allow_op, .mem_address, .mem_op, .mem_data_in,
    .start_access, .mem_data_ready, .mem_data_out, .mem_op_done
  );

  tb_line_memory i_mem (
    .clk, .reset, .mem_op_init, .mem_op, .start_access, .mem_op_done,
    .mem_address, .mem_data_in, .allow_op, .mem_data_ready, .mem_data_out
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected)
      report_failure($sformatf("** Error: %s expected %h got %h", name, expected, actual));
  endtask

  task automatic check_line(string name, line_t expected, line_t actual);
    if (actual !== expected)
      report_failure($sformatf("** Error: %s expected %h got %h", name, expected, actual));
  endtask

  task automatic check_addr(string name, addr_t expected, addr_t actual);
    if (actual !== expected)
      report_failure($sformatf("** Error: %s expected %h got %h", name, expected, actual));
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected)
      report_failure($sformatf("** Error: %s expected %h got %h", name, expected, actual));
  endtask

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function logic [31:0] random_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // Memory contents before any write-back
  function automatic word_t memory_word_default(addr_t a);
    return a ^ {a[7:0], a[31:8]} ^ 32'hc3a5_1e0f;
  endfunction

  function word_t shadow_word(addr_t wa);
    return shadow.exists(wa) ? shadow[wa] : memory_word_default(wa);
  endfunction

  function line_t shadow_line(addr_t base);
    line_t l;
    for (int w = 0; w < WORDS_PER_LINE; w++)
      l[w*WORD_W +: WORD_W] = shadow_word(base + addr_t'(4 * w));
    return l;
  endfunction

  // Expected load value and memory traffic of one access
  function void reference_access(logic is_read, logic is_byte, addr_t a, word_t d);
    tag_t  t;
    addr_t wa;
    word_t w;
    int    h;
    int    v;
    age_t  old;
    t  = a[31:4];
    wa = {a[31:2], 2'b00};
    h  = -1;
    v  = 0;
    for (int i = NUM_LINES - 1; i >= 0; i--)
      if (ref_valid[i] && ref_tag[i] == t)
        h = i;
    exp_read = is_read;
    exp_miss = (h < 0);
    exp_wb   = 1'b0;
    if (exp_miss)
    begin
      for (int i = 0; i < NUM_LINES; i++)
        if (ref_age[i] == 2'd0)
          v = i;
      exp_wb          = ref_valid[v] && ref_dirty[v];
      exp_wb_addr     = {ref_tag[v], 4'b0000};
      exp_wb_line     = shadow_line(exp_wb_addr);
      exp_refill_addr = {t, 4'b0000};
      ref_tag[v]      = t;
      ref_valid[v]    = 1'b1;
      ref_dirty[v]    = 1'b0;
      h = v;
    end
    old = ref_age[h];
    for (int j = 0; j < NUM_LINES; j++)
      if (j != h && ref_age[j] > old)
        ref_age[j] = ref_age[j] - 2'd1;
    ref_age[h] = 2'd3;
    w = shadow_word(wa);
    if (is_read)
      exp_load = is_byte ? {24'h0, w[a[1:0]*8 +: 8]} : w;
    else
    begin
      ref_dirty[h] = 1'b1;
      if (is_byte)
        w[a[1:0]*8 +: 8] = d[7:0];
      else
        w = d;
      shadow[wa] = w;
    end
  endfunction

  // Monitor of the DUT ports sampled on the rising edge
  always @(posedge clk)
  begin
    if (!reset && !pending)
    begin
      check_flag("data_ready", 1'b0, data_ready);
      check_flag("mem_op_init", 1'b0, mem_op_init);
      check_flag("mem_op_done", 1'b0, mem_op_done);
      check_flag("start_access", 1'b0, start_access);
    end
    else if (!reset)
    begin
      cyc = cyc + 1;
      if (start_access)
        check_flag("allow_op", 1'b1, allow_op);
      // Strobe drops in the cycle after each transfer
      if (xfer_end)
        check_flag("start_access", 1'b0, start_access);
      xfer_end = start_access && mem_data_ready;
      if (mem_op_done)
      begin
        check_flag("mem_op_init", 1'b0, mem_op_init);
        done_cnt = done_cnt + 1;
        done_cyc = cyc;
      end
      if (start_access && mem_data_ready)
      begin
        if (!exp_miss)
          report_failure("memory transfer on a cache hit");
        if (exp_wb && n_xfer == 0)
        begin
          check_flag("mem_op", 1'b1, mem_op);
          check_addr("mem_address", exp_wb_addr, mem_address);
          check_line("mem_data_in", exp_wb_line, mem_data_in);
        end
        else
        begin
          check_flag("mem_op", 1'b0, mem_op);
          check_addr("mem_address", exp_refill_addr, mem_address);
        end
        n_xfer = n_xfer + 1;
      end
      if (data_ready)
      begin
        if (!exp_miss && cyc != 3)
          report_failure("hit did not finish 2 cycles after access");
        if (n_xfer != (exp_miss ? (exp_wb ? 2 : 1) : 0))
          report_failure("wrong number of memory transfers for this access");
        if (done_cnt != (exp_miss ? 1 : 0))
          report_failure("wrong number of mem_op_done pulses");
        if (exp_miss && done_cyc != cyc - 1)
          report_failure("data_ready did not follow mem_op_done by one cycle");
        if (exp_read)
          check_word("data_out", exp_load, data_out);
        pending = 1'b0;
      end
    end
  end

  task automatic run_access(logic is_read, logic is_byte, addr_t a, word_t d);
    reference_access(is_read, is_byte, a, d);
    @(negedge clk);
    cyc      = 0;
    n_xfer   = 0;
    xfer_end = 1'b0;
    done_cnt = 0;
    done_cyc = 0;
    pending  = 1'b1;
    access   = 1'b1;
    op       = is_read;
    byte_op  = is_byte;
    address  = a;
    data_in  = d;
    @(negedge clk);
    access = 1'b0;
    while (pending)
      @(negedge clk);
  endtask

  initial
  begin
    logic  is_read;
    logic  is_byte;
    addr_t a;
    word_t d;
    reset   = 1'b1;
    access  = 1'b0;
    op      = 1'b0;
    byte_op = 1'b0;
    address = '0;
    data_in = '0;
    pending = 1'b0;
    for (int i = 0; i < NUM_LINES; i++)
    begin
      ref_valid[i] = 1'b0;
      ref_dirty[i] = 1'b0;
      ref_tag[i]   = '0;
      ref_age[i]   = age_t'(i);
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;
    // Idle outputs are checked by the monitor over these cycles
    repeat (3) @(negedge clk);
    for (int n = 0; n < NUM_ACCESSES; n++)
    begin
      is_read = 1'(random_bits(1));
      is_byte = 1'(random_bits(1));
      if (n == 0)
        is_read = 1'b1;
      a = line_bases[random_bits(3) % 6];
      a[3:2] = 2'(random_bits(2));
      a[1:0] = is_byte ? 2'(random_bits(2)) : 2'b00;
      d = random_bits(32);
      run_access(is_read, is_byte, a, d);
    end
    repeat (2) @(negedge clk);
    $display("NO ERRORS");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before all accesses completed");
  end

endmodule

`default_nettype wire

// ==== compile.f ====
design/dcache_pkg.sv
design/cache_line.sv
design/line_select.sv
design/cache_controller.sv
design/dcache.sv
tb/tb_line_memory.sv
tb/tb_dcache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_dcache -o sim_dcache
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/sim_dcache
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi

exit 0
